/* all.f */
+incdir+rtl
rtl/alut_entry_pkg.sv
rtl/alut_wb_pkg.sv
rtl/alut_mem.sv
rtl/alut_addr_checker.sv
rtl/alut_age_checker.sv
rtl/alut_wb_regs.sv
rtl/alut_top.sv
verification/alut_tb.sv

/* rtl/alut_addr_checker.sv */
// learn and lookup sequencer on memory port a, fixed 3 cycle latency
// req is taken only while busy is low, a req during busy is dropped
// a hash collision overwrites the old entry, no buckets

`timescale 1ns/1ps
`default_nettype none

`include "alut_params.svh"

module alut_addr_checker (
   input  wire logic                    pclk1,
   input  wire logic                    rst_n,
   // frame side
   input  wire logic                    req,
   input  wire logic [`ALUT_MAC_W-1:0]  src_mac,
   input  wire logic [`ALUT_MAC_W-1:0]  dst_mac,
   input  wire logic [`ALUT_PORT_W-1:0] src_port,
   output      logic                    busy,
   output      logic                    done,
   output      logic                    hit,
   output      logic [`ALUT_PORT_W-1:0] dst_port,
   // timestamp from age checker
   input  wire logic [`ALUT_AGE_W-1:0]  now,
   // memory port a
   output      logic [`ALUT_AW-1:0]     addr_a,
   output      logic                    we_a,
   output      logic [`ALUT_DW-1:0]     wdata_a,
   input  wire logic [`ALUT_DW-1:0]     rdata_a
);

   typedef enum logic [1:0] {
      S_IDLE,     // waiting for req
      S_LEARN,    // cycle 1, write source entry
      S_LOOKUP,   // cycle 2, read destination hash
      S_REPORT    // cycle 3, rdata valid, done
   } state_e;

   state_e state_q;

   logic [`ALUT_MAC_W-1:0]  src_mac_q;    // latched request
   logic [`ALUT_MAC_W-1:0]  dst_mac_q;
   logic [`ALUT_PORT_W-1:0] src_port_q;
   logic                    hit_q;        // result held between dones
   logic [`ALUT_PORT_W-1:0] dst_port_q;

   alut_entry_pkg::alut_entry_t wr_entry;
   alut_entry_pkg::alut_entry_t rd_entry;
   logic                        lookup_hit;

   // ------------------------------------------------------------------------
   // sequencer
   // ------------------------------------------------------------------------
   always_ff @(posedge pclk1 or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state_q    <= S_IDLE;
         hit_q      <= 1'b0;
         dst_port_q <= '0;
      end
      else
      begin
         case (state_q)
            S_IDLE:   if (req) state_q <= S_LEARN;   // cycle 0 sample
            S_LEARN:  state_q <= S_LOOKUP;
            S_LOOKUP: state_q <= S_REPORT;
            S_REPORT:
            begin
               state_q    <= S_IDLE;
               hit_q      <= lookup_hit;           // hold for the user
               dst_port_q <= rd_entry.port;
            end
            default:  state_q <= S_IDLE;
         endcase
      end
   end

   // request fields, only loaded on the sample edge
   always_ff @(posedge pclk1)
   begin
      if (state_q == S_IDLE && req)
      begin
         src_mac_q  <= src_mac;
         dst_mac_q  <= dst_mac;
         src_port_q <= src_port;
      end
   end

   // ------------------------------------------------------------------------
   // memory side
   // ------------------------------------------------------------------------
   always_comb
   begin
      wr_entry.mac   = src_mac_q;
      wr_entry.port  = src_port_q;
      wr_entry.valid = 1'b1;
      wr_entry.stamp = now;   // learn refreshes the age
   end

   assign we_a    = (state_q == S_LEARN);
   assign addr_a  = we_a ? alut_entry_pkg::hash(src_mac_q)
                         : alut_entry_pkg::hash(dst_mac_q);
   assign wdata_a = wr_entry;

   assign rd_entry   = rdata_a;
   assign lookup_hit = rd_entry.valid && (rd_entry.mac == dst_mac_q);   // miss means flood

   // ------------------------------------------------------------------------
   // frame side outputs
   // ------------------------------------------------------------------------
   assign busy     = (state_q != S_IDLE);
   assign done     = (state_q == S_REPORT);
   assign hit      = done ? lookup_hit : hit_q;
   assign dst_port = done ? rd_entry.port : dst_port_q;

   a_done_then_idle: assert property (@(posedge pclk1) disable iff (!rst_n)
      done |=> !busy);

   a_done_single: assert property (@(posedge pclk1) disable iff (!rst_n)
      done |=> !done);

endmodule

`default_nettype wire

/* rtl/alut_age_checker.sv */
// timestamp counter and aging sweep on memory port b, 3 cycles per entry
// no write-back during the first full sweep after reset
// write-back is dropped when port a wrote the same address recently

`timescale 1ns/1ps
`default_nettype none

`include "alut_params.svh"

module alut_age_checker (
   input  wire logic                   pclk1,
   input  wire logic                   rst_n,
   input  wire logic                   age_en,
   input  wire logic [`ALUT_AGE_W-1:0] age_limit,
   input  wire logic [`ALUT_AW-1:0]    addr_a,      // port a snoop
   input  wire logic                   we_a,
   output      logic [`ALUT_AGE_W-1:0] now,
   output      logic [`ALUT_AW-1:0]    addr_b,
   output      logic                   we_b,
   output      logic [`ALUT_DW-1:0]    wdata_b,
   input  wire logic [`ALUT_DW-1:0]    rdata_b,
   output      logic                   aged_pulse
);

   typedef enum logic [1:0] {P_READ, P_CMP, P_WRITE} phase_e;

   phase_e                      phase_q;
   logic [`ALUT_AW-1:0]         sweep_q;      // entry under test
   logic                        swept_q;      // first sweep finished
   logic [`ALUT_AGE_W-1:0]      now_q;
   logic                        aged_q;       // entry found too old
   logic                        we_a_d1, we_a_d2;
   logic [`ALUT_AW-1:0]         addr_a_d1, addr_a_d2;
   alut_entry_pkg::alut_entry_t rd_entry;
   alut_entry_pkg::alut_entry_t entry_q;      // copy for write-back
   logic                        too_old;
   logic                        cancel;

   assign rd_entry = rdata_b;
   assign too_old  = rd_entry.valid && ((now_q - rd_entry.stamp) > age_limit);

   // ------------------------------------------------------------------------
   // sweep and timestamp
   // ------------------------------------------------------------------------
   always_ff @(posedge pclk1 or negedge rst_n)
   begin
      if (!rst_n)
      begin
         phase_q <= P_READ;
         sweep_q <= '0;
         swept_q <= 1'b0;
         now_q   <= '0;
         aged_q  <= 1'b0;
         we_a_d1 <= 1'b0;
         we_a_d2 <= 1'b0;
      end
      else
      begin
         now_q   <= now_q + 1'b1;   // free running, wraps
         we_a_d1 <= we_a;
         we_a_d2 <= we_a_d1;
         case (phase_q)
            P_READ:  phase_q <= P_CMP;
            P_CMP:
            begin
               phase_q <= P_WRITE;
               aged_q  <= too_old && age_en && swept_q;
            end
            default:
            begin
               phase_q <= P_READ;
               aged_q  <= 1'b0;
               if (sweep_q == `ALUT_AW'(`ALUT_DEPTH - 1))
               begin
                  sweep_q <= '0;      // wrap, table fully visited
                  swept_q <= 1'b1;
               end
               else
                  sweep_q <= sweep_q + 1'b1;
            end
         endcase
      end
   end

   always_ff @(posedge pclk1)
   begin
      addr_a_d1 <= addr_a;
      addr_a_d2 <= addr_a_d1;
      if (phase_q == P_CMP)
         entry_q <= rd_entry;
   end

   // port a wrote this entry since our read, its data is newer
   assign cancel = (we_a && addr_a == sweep_q) || (we_a_d1 && addr_a_d1 == sweep_q)
                || (we_a_d2 && addr_a_d2 == sweep_q);

   always_comb
   begin
      wdata_b       = entry_q;
      wdata_b[`ALUT_AGE_W] = 1'b0;   // valid bit sits just above stamp
   end

   assign now        = now_q;
   assign addr_b     = sweep_q;
   assign we_b       = (phase_q == P_WRITE) && aged_q && age_en && !cancel;
   assign aged_pulse = we_b;

   a_we_b_enabled: assert property (@(posedge pclk1) disable iff (!rst_n)
      we_b |-> (age_en && $past(age_en)));

endmodule

`default_nettype wire

/* rtl/alut_entry_pkg.sv */
// table entry layout and the mac hash
// hash is a plain xor fold, so collisions are easy to build on purpose
// field order in the struct fixes the bit layout in memory

`default_nettype none

`include "alut_params.svh"

package alut_entry_pkg;

   // byte slices folded into one table address
   localparam int HASH_SLICES = `ALUT_MAC_W / `ALUT_AW;

   // one table entry, msb first
   typedef struct packed {
      logic [`ALUT_MAC_W-1:0]  mac;    // learned source mac
      logic [`ALUT_PORT_W-1:0] port;   // ingress port it came in on
      logic                    valid;  // cleared by aging
      logic [`ALUT_AGE_W-1:0]  stamp;  // time of last learn
   } alut_entry_t;

   // xor fold of the mac into a table index
   function automatic logic [`ALUT_AW-1:0] hash(input logic [`ALUT_MAC_W-1:0] mac);
      logic [`ALUT_AW-1:0] h;
      h = '0;
      for (int i = 0; i < HASH_SLICES; i++)
      begin
         h ^= mac[i*`ALUT_AW +: `ALUT_AW];   // one byte per step
      end
      return h;
   endfunction

endpackage

`default_nettype wire

/* rtl/alut_mem.sv */
// dual port table ram, each port reads or writes once per cycle
// reads are registered, one cycle latency, contents undefined after reset
// both ports writing one address in one cycle is not allowed

`timescale 1ns/1ps
`default_nettype none

`include "alut_params.svh"

module alut_mem #(
   parameter int DW    = `ALUT_DW,      // entry width
   parameter int DEPTH = `ALUT_DEPTH    // entries
) (
   input  wire logic                pclk1,
   input  wire logic [`ALUT_AW-1:0] addr_a,    // address checker side
   input  wire logic                we_a,
   input  wire logic [DW-1:0]       wdata_a,
   output      logic [DW-1:0]       rdata_a,
   input  wire logic [`ALUT_AW-1:0] addr_b,    // age checker side
   input  wire logic                we_b,
   input  wire logic [DW-1:0]       wdata_b,
   output      logic [DW-1:0]       rdata_b
);

   logic [DW-1:0] mem_q [DEPTH];   // table storage

   // ------------------------------------------------------------------------
   // port a
   // ------------------------------------------------------------------------
   always @(posedge pclk1)
   begin
      if (we_a)
         mem_q[addr_a] <= wdata_a;   // learn
      else
         rdata_a <= mem_q[addr_a];   // lookup read
   end

   // ------------------------------------------------------------------------
   // port b
   // ------------------------------------------------------------------------
   always @(posedge pclk1)
   begin
      if (we_b)
         mem_q[addr_b] <= wdata_b;   // aging write-back
      else
         rdata_b <= mem_q[addr_b];   // sweep read
   end

   // age checker must back off from anything port a touches
   a_no_same_addr_write: assert property (@(posedge pclk1)
      !(we_a && we_b && (addr_a == addr_b)));

endmodule

`default_nettype wire

/* rtl/alut_params.svh */
// table geometry and field widths for the switch address lookup table
// ALUT_DW must stay equal to the packed entry struct width
// Wishbone data width must hold the 32-bit timestamp for NOW readback

`ifndef ALUT_PARAMS_SVH
`define ALUT_PARAMS_SVH

// ------------------------------------------------------------------------
// table geometry
// ------------------------------------------------------------------------
`define ALUT_DEPTH   256                      // entries, one per hash value
`define ALUT_AW      8                        // table address, hash width

// entry fields
`define ALUT_MAC_W   48                       // ethernet mac
`define ALUT_PORT_W  2                        // four switch ports
`define ALUT_AGE_W   32                       // timestamp in pclk1 cycles
`define ALUT_DW      (`ALUT_MAC_W + `ALUT_PORT_W + 1 + `ALUT_AGE_W)

// ------------------------------------------------------------------------
// wishbone
// ------------------------------------------------------------------------
`define ALUT_WB_AW   4                        // byte offsets 0x0..0xc
`define ALUT_WB_DW   32

`endif

/* rtl/alut_top.sv */
// address lookup table top, four port switch, 256 entry direct mapped
// frame side and wishbone side share pclk1 and rst_n

`timescale 1ns/1ps
`default_nettype none

`include "alut_params.svh"

module alut_top (
   input  wire logic                    pclk1,
   input  wire logic                    rst_n,
   // frame side
   input  wire logic                    req,
   input  wire logic [`ALUT_MAC_W-1:0]  src_mac,
   input  wire logic [`ALUT_MAC_W-1:0]  dst_mac,
   input  wire logic [`ALUT_PORT_W-1:0] src_port,
   output      logic                    busy,
   output      logic                    done,
   output      logic                    hit,
   output      logic [`ALUT_PORT_W-1:0] dst_port,
   // wishbone
   input  wire logic                    cyc,
   input  wire logic                    stb,
   input  wire logic                    we,
   input  wire logic [`ALUT_WB_AW-1:0]  adr,
   input  wire logic [`ALUT_WB_DW-1:0]  dat_w,
   output      logic [`ALUT_WB_DW-1:0]  dat_r,
   output      logic                    ack
);

   // ------------------------------------------------------------------------
   // internal nets
   // ------------------------------------------------------------------------
   logic [`ALUT_AW-1:0]    addr_a, addr_b;
   logic                   we_a, we_b;
   logic [`ALUT_DW-1:0]    wdata_a, wdata_b, rdata_a, rdata_b;
   logic [`ALUT_AGE_W-1:0] now, age_limit;
   logic                   age_en, aged_pulse;

   alut_mem #(.DW(`ALUT_DW), .DEPTH(`ALUT_DEPTH)) u_mem (
      .pclk1, .addr_a, .we_a, .wdata_a, .rdata_a,
      .addr_b, .we_b, .wdata_b, .rdata_b
   );

   alut_addr_checker u_addr_checker (
      .pclk1, .rst_n, .req, .src_mac, .dst_mac, .src_port,
      .busy, .done, .hit, .dst_port, .now,
      .addr_a, .we_a, .wdata_a, .rdata_a
   );

   alut_age_checker u_age_checker (
      .pclk1, .rst_n, .age_en, .age_limit, .addr_a, .we_a,
      .now, .addr_b, .we_b, .wdata_b, .rdata_b, .aged_pulse
   );

   alut_wb_regs u_wb_regs (
      .pclk1, .rst_n, .cyc, .stb, .we, .adr, .dat_w, .dat_r, .ack,
      .now, .aged_pulse, .age_en, .age_limit
   );

endmodule

`default_nettype wire

/* rtl/alut_wb_pkg.sv */
// register map of the lookup table control slave
// offsets are byte addresses, only word aligned offsets decode

`default_nettype none

`include "alut_params.svh"

package alut_wb_pkg;

   // register byte offsets
   typedef enum logic [`ALUT_WB_AW-1:0] {
      REG_CTRL       = 4'h0,   // control bits
      REG_AGE_LIMIT  = 4'h4,   // max idle time in cycles
      REG_NOW        = 4'h8,   // timestamp, read only
      REG_AGED_COUNT = 4'hC    // aged entries, write clears
   } reg_addr_e;

   // CTRL bits
   localparam int CTRL_AGE_EN = 0;   // enable aging write-back

endpackage

`default_nettype wire

/* rtl/alut_wb_regs.sv */
// wishbone classic slave for the lookup table control registers
// one cycle ack, no wait states, writes to NOW are ignored
// AGED_COUNT saturates and any write to it clears it

`timescale 1ns/1ps
`default_nettype none

`include "alut_params.svh"

module alut_wb_regs (
   input  wire logic                   pclk1,
   input  wire logic                   rst_n,
   // wishbone
   input  wire logic                   cyc,
   input  wire logic                   stb,
   input  wire logic                   we,
   input  wire logic [`ALUT_WB_AW-1:0] adr,
   input  wire logic [`ALUT_WB_DW-1:0] dat_w,
   output      logic [`ALUT_WB_DW-1:0] dat_r,
   output      logic                   ack,
   // age checker
   input  wire logic [`ALUT_AGE_W-1:0] now,
   input  wire logic                   aged_pulse,
   output      logic                   age_en,
   output      logic [`ALUT_AGE_W-1:0] age_limit
);

   alut_wb_pkg::reg_addr_e reg_sel;
   logic                   access;       // ack goes high on this edge
   logic                   wr_en;
   logic [`ALUT_WB_DW-1:0] aged_count_q;

   assign reg_sel = alut_wb_pkg::reg_addr_e'(adr);
   assign access  = cyc && stb && !ack;
   assign wr_en   = access && we;

   // ------------------------------------------------------------------------
   // ack and writable registers
   // ------------------------------------------------------------------------
   always_ff @(posedge pclk1 or negedge rst_n)
   begin
      if (!rst_n)
      begin
         ack          <= 1'b0;
         age_en       <= 1'b0;
         age_limit    <= '0;
         aged_count_q <= '0;
      end
      else
      begin
         ack <= access;
         if (wr_en && reg_sel == alut_wb_pkg::REG_CTRL)
            age_en <= dat_w[alut_wb_pkg::CTRL_AGE_EN];
         if (wr_en && reg_sel == alut_wb_pkg::REG_AGE_LIMIT)
            age_limit <= dat_w;
         if (wr_en && reg_sel == alut_wb_pkg::REG_AGED_COUNT)
            aged_count_q <= '0;                       // clear beats a new pulse
         else if (aged_pulse && aged_count_q != '1)
            aged_count_q <= aged_count_q + 1'b1;      // saturating
      end
   end

   // ------------------------------------------------------------------------
   // read data, presented with ack
   // ------------------------------------------------------------------------
   always_ff @(posedge pclk1)
   begin
      if (access && !we)
      begin
         case (reg_sel)
            alut_wb_pkg::REG_CTRL:       dat_r <= `ALUT_WB_DW'(age_en);
            alut_wb_pkg::REG_AGE_LIMIT:  dat_r <= age_limit;
            alut_wb_pkg::REG_NOW:        dat_r <= now;
            alut_wb_pkg::REG_AGED_COUNT: dat_r <= aged_count_q;
            default:                     dat_r <= '0;   // unmapped offset
         endcase
      end
   end

   a_ack_one_cycle: assert property (@(posedge pclk1) disable iff (!rst_n)
      (cyc && stb && !ack) |=> (ack ##1 !ack));

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# compile the lookup table testbench with Verilator and run it
# exit status is non-zero when the build fails or the testbench stops on $fatal
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal \
   -f all.f --top-module alut_tb \
   && ./obj_dir/Valut_tb \
   || { echo "build or simulation failed"; exit 1; }

/* verification/alut_tb.sv */
// testbench for the lookup table top, scoreboard is one slot per hash
// table memory is undefined after reset, the first full sweep is waited out
// aging is modelled only at one checkpoint after a long idle time

`timescale 1ns/1ps
`default_nettype none

`include "alut_params.svh"

module alut_tb;

   localparam int TIMEOUT = 100;                 // cycles per handshake wait

   logic                    pclk1, rst_n;
   logic                    req, busy, done, hit;
   logic [`ALUT_MAC_W-1:0]  src_mac, dst_mac;
   logic [`ALUT_PORT_W-1:0] src_port, dst_port;
   logic                    cyc, stb, we, ack;
   logic [`ALUT_WB_AW-1:0]  adr;
   logic [`ALUT_WB_DW-1:0]  dat_w, dat_r;

   logic                    sb_valid [`ALUT_DEPTH];   // expected table
   logic [`ALUT_MAC_W-1:0]  sb_mac   [`ALUT_DEPTH];
   logic [`ALUT_PORT_W-1:0] sb_port  [`ALUT_DEPTH];

   logic [31:0]             lcg_state;
   int                      done_count;
   logic [`ALUT_MAC_W-1:0]  mac_a, mac_b, mac_c, mac_d, mac_e, mac_k;
   logic [`ALUT_MAC_W-1:0]  idle_mac [8];              // entries left to age
   logic [31:0]             rd, t0, t1, n_idle;

   alut_top dut (
      .pclk1, .rst_n, .req, .src_mac, .dst_mac, .src_port,
      .busy, .done, .hit, .dst_port,
      .cyc, .stb, .we, .adr, .dat_w, .dat_r, .ack
   );

   initial
   begin
      pclk1 = 1'b0;
      forever #2 pclk1 = ~pclk1;   // 4 ns period
   end

   always @(posedge pclk1)
      if (rst_n && done)
         done_count <= done_count + 1;

   // ------------------------------------------------------------------------
   // helpers
   // ------------------------------------------------------------------------
   task automatic report_error(input string line);
      $display("%s", line);
      $display("ERRORS FOUND");
      $fatal(1, "simulation stopped on the first error");
   endtask

   task automatic expect_true(input logic cond, input string msg);
      assert (cond === 1'b1)
      else report_error($sformatf("FAILED at %0t ns: %s", $time, msg));
   endtask

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   // random mac, low byte patched so the xor fold lands on target
   function automatic logic [`ALUT_MAC_W-1:0] mac_with_hash(input logic [7:0] target);
      logic [`ALUT_MAC_W-1:0] m;
      logic [31:0]            r;
      r        = lcg_next();
      m[47:16] = lcg_next();
      m[15:0]  = r[31:16];                 // upper lcg bits are less regular
      m[7:0]   = m[7:0] ^ alut_entry_pkg::hash(m) ^ target;
      return m;
   endfunction

   task automatic wb_access(input logic write, input logic [3:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
      int n;
      cyc   = 1'b1;
      stb   = 1'b1;
      we    = write;
      adr   = addr;
      dat_w = wdata;
      n     = 0;
      do
      begin
         @(negedge pclk1);
         n++;
         if (n > TIMEOUT)
            report_error("timeout, no wishbone ack");
      end while (!ack);
      rdata = dat_r;                        // valid with ack
      cyc   = 1'b0;
      stb   = 1'b0;
      we    = 1'b0;
   endtask

   task automatic wb_write(input logic [3:0] addr, input logic [31:0] wdata);
      logic [31:0] unused;
      wb_access(1'b1, addr, wdata, unused);
   endtask

   task automatic wb_read(input logic [3:0] addr, output logic [31:0] rdata);
      wb_access(1'b0, addr, 32'h0, rdata);
   endtask

   // one frame, learns src and looks up dst, hold keeps req up during busy
   task automatic lookup(input logic [`ALUT_MAC_W-1:0] src, input logic [1:0] port,
                         input logic [`ALUT_MAC_W-1:0] dst, input int hold);
      logic [7:0] sh, dh;
      logic       exp_hit;
      logic [1:0] exp_port;
      int         n;
      sh = alut_entry_pkg::hash(src);
      dh = alut_entry_pkg::hash(dst);
      sb_valid[sh] = 1'b1;                  // learn lands before the read
      sb_mac[sh]   = src;
      sb_port[sh]  = port;
      exp_hit  = sb_valid[dh] && (sb_mac[dh] == dst);
      exp_port = sb_port[dh];
      n = 0;
      while (busy)
      begin
         @(negedge pclk1);
         n++;
         if (n > TIMEOUT)
            report_error("timeout, address checker stays busy");
      end
      src_mac  = src;
      dst_mac  = dst;
      src_port = port;
      req      = 1'b1;
      @(negedge pclk1);                     // sample edge passed
      repeat (hold) @(negedge pclk1);
      req = 1'b0;
      n   = 0;
      while (!done)
      begin
         @(negedge pclk1);
         n++;
         if (n > TIMEOUT)
            report_error("timeout, no done from the address checker");
      end
      expect_true(hit == exp_hit, $sformatf("hit %0b, expected %0b for %h", hit, exp_hit, dst));
      if (exp_hit)
         expect_true(dst_port == exp_port,
                     $sformatf("dst_port %0d, expected %0d", dst_port, exp_port));
      @(negedge pclk1);
   endtask

   // ------------------------------------------------------------------------
   // protocol checks
   // ------------------------------------------------------------------------
   a_latency: assert property (@(posedge pclk1) disable iff (!rst_n)
      (req && !busy) |=> (!done ##1 !done ##1 done))
      else report_error($sformatf("FAILED at %0t ns: done not 3 cycles after req", $time));

   a_ack_rise: assert property (@(posedge pclk1) disable iff (!rst_n)
      (cyc && stb && !ack) |=> ack)
      else report_error($sformatf("FAILED at %0t ns: ack missing", $time));

   a_ack_pulse: assert property (@(posedge pclk1) disable iff (!rst_n)
      ack |=> !ack)
      else report_error($sformatf("FAILED at %0t ns: ack longer than one cycle", $time));

   // ------------------------------------------------------------------------
   // stimulus
   // ------------------------------------------------------------------------
   initial
   begin
      rst_n      = 1'b0;
      req        = 1'b0;
      src_mac    = '0;
      dst_mac    = '0;
      src_port   = '0;
      cyc        = 1'b0;
      stb        = 1'b0;
      we         = 1'b0;
      adr        = '0;
      dat_w      = '0;
      done_count = 0;
      lcg_state  = 32'haddd;
      for (int h = 0; h < `ALUT_DEPTH; h++)
         sb_valid[h] = 1'b0;
      repeat (3) @(negedge pclk1);
      rst_n = 1'b1;
      repeat (800) @(negedge pclk1);        // first sweep, no write-back yet

      // registers
      wb_write(alut_wb_pkg::REG_AGE_LIMIT, 32'h0bad_cafe);
      wb_read(alut_wb_pkg::REG_AGE_LIMIT, rd);
      expect_true(rd == 32'h0bad_cafe, $sformatf("AGE_LIMIT read %h", rd));
      wb_write(alut_wb_pkg::REG_CTRL, 32'h1 << alut_wb_pkg::CTRL_AGE_EN);
      wb_read(alut_wb_pkg::REG_CTRL, rd);
      expect_true(rd == 32'h1, $sformatf("CTRL read %h, expected 1", rd));
      wb_write(alut_wb_pkg::REG_CTRL, 32'h0);
      wb_read(alut_wb_pkg::REG_CTRL, rd);
      expect_true(rd == 32'h0, $sformatf("CTRL read %h, expected 0", rd));
      wb_read(alut_wb_pkg::REG_NOW, t0);
      repeat (10) @(negedge pclk1);
      wb_read(alut_wb_pkg::REG_NOW, t1);
      expect_true(t1 > t0, $sformatf("NOW did not advance, %0d then %0d", t0, t1));
      wb_write(alut_wb_pkg::REG_NOW, 32'h0);   // read only
      wb_read(alut_wb_pkg::REG_NOW, rd);
      expect_true(rd > t1, $sformatf("NOW took a write, read %0d", rd));

      // learn, hit, miss, back-pressure, collision
      mac_a = mac_with_hash(8'h40);
      mac_b = mac_with_hash(8'h40);          // collides with a
      mac_c = mac_with_hash(8'h41);
      mac_d = mac_with_hash(8'h40);          // never learned
      lookup(mac_a, 2'd1, mac_a, 0);
      lookup(mac_c, 2'd2, mac_a, 0);
      t0 = done_count;
      lookup(mac_c, 2'd2, mac_d, 2);         // req held through busy
      repeat (6) @(negedge pclk1);
      expect_true(done_count == t0 + 1, $sformatf("%0d dones for one req", done_count - t0));
      lookup(mac_b, 2'd3, mac_b, 0);
      lookup(mac_c, 2'd2, mac_a, 0);
      lookup(mac_c, 2'd2, mac_b, 0);

      // aging
      for (int i = 0; i < 6; i++)
      begin
         idle_mac[i] = mac_with_hash(8'h10 + 8'(i));
         lookup(idle_mac[i], 2'(i), idle_mac[i], 0);
      end
      idle_mac[6] = mac_b;
      idle_mac[7] = mac_c;
      mac_k  = mac_with_hash(8'h80);
      mac_e  = mac_with_hash(8'h81);         // partner frame, reads mac_k back
      n_idle = 0;
      for (int h = 0; h < `ALUT_DEPTH; h++)
         if (sb_valid[h] && h != 8'h80)
            n_idle++;
      wb_write(alut_wb_pkg::REG_AGE_LIMIT, 32'd100);
      wb_write(alut_wb_pkg::REG_CTRL, 32'h1 << alut_wb_pkg::CTRL_AGE_EN);
      lookup(mac_k, 2'd2, mac_k, 0);
      for (int i = 0; i < 24; i++)
      begin
         lookup(mac_e, 2'd0, mac_k, 0);       // mac_k still there
         lookup(mac_k, 2'd2, mac_e, 0);       // refresh well inside the limit
         repeat (45) @(negedge pclk1);
      end
      for (int h = 0; h < `ALUT_DEPTH; h++)
         if (h != 8'h80 && h != 8'h81)
            sb_valid[h] = 1'b0;               // idle far beyond limit plus sweep
      for (int i = 0; i < 8; i++)
         lookup(mac_k, 2'd2, idle_mac[i], 0);
      lookup(mac_e, 2'd0, mac_k, 0);
      wb_read(alut_wb_pkg::REG_AGED_COUNT, rd);
      expect_true(rd >= n_idle, $sformatf("AGED_COUNT %0d, expected at least %0d", rd, n_idle));
      wb_write(alut_wb_pkg::REG_CTRL, 32'h0);
      wb_write(alut_wb_pkg::REG_AGED_COUNT, 32'h5a5a_5a5a);
      wb_read(alut_wb_pkg::REG_AGED_COUNT, rd);
      expect_true(rd == 32'h0, $sformatf("AGED_COUNT not cleared, read %0d", rd));

      $display("NO ERRORS");
      $finish;
   end

endmodule

`default_nettype wire
